/* hw/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN_MAX = 64; // stage structs are sized for the widest core

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_e;

    typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;

    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_FOUR, SRC_B_IMM, SRC_B_ZERO} src_b_e;

    typedef struct packed {
        logic                valid;
        logic [XLEN_MAX-1:0] pc;
        logic [XLEN_MAX-1:0] src1;
        logic [XLEN_MAX-1:0] src2;
        logic [31:0]         imm;    // sign-extended to 32, widened in execute
        logic [4:0]          rd;
        alu_op_e             alu_op;
        src_a_e              src_a;
        src_b_e              src_b;
        branch_e             branch;
        logic                reg_wr;
        logic                is_ecall;
        logic                illegal;
    } dec_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [XLEN_MAX-1:0] result;
        logic                reg_wr;
        logic                is_jmp;
        logic [XLEN_MAX-1:0] nxtpc;
        logic                is_ecall;
        logic                illegal;
    } ex_t;

endpackage

`default_nettype wire

/* hw/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0]     a,
    input  logic [XLEN-1:0]     b,
    input  rv_exec_pkg::alu_op_e op,
    output logic [XLEN-1:0]     result,
    output logic                zero
);
    import rv_exec_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;

    assign shamt = b[SHW-1:0]; // only the low bits count, 6 at rv64 and 5 at rv32
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign zero = ~|result; // beq and bne look at this after a subtract

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module branch_unit #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     src1,
    input  logic [XLEN-1:0]     imm,
    input  rv_exec_pkg::branch_e branch,
    input  logic                zero,
    input  logic                lt,
    output logic [XLEN-1:0]     nxtpc,
    output logic                taken
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] reg_imm;

    assign pc_imm  = pc + imm;
    assign reg_imm = src1 + imm;

    always_comb begin
        case (branch)
            BR_JAL, BR_JALR: taken = 1'b1;
            BR_BEQ:          taken = zero;
            BR_BNE:          taken = !zero;
            BR_BLT, BR_BLTU: taken = lt; // lt is bit 0 of the slt or sltu result
            BR_BGE, BR_BGEU: taken = !lt;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken) nxtpc = pc + XLEN'(4);
        else if (branch == BR_JALR) nxtpc = {reg_imm[XLEN-1:1], 1'b0};
        else nxtpc = pc_imm;
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               block,
    input  logic               in_valid,
    input  logic [31:0]        instr,
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    rs1_data,
    input  logic [XLEN-1:0]    rs2_data,
    output rv_exec_pkg::dec_t  dec
);
    import rv_exec_pkg::*;

    logic            valid_q;
    logic [31:0]     instr_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [31:0]     imm_i, imm_b, imm_u, imm_j;
    logic            shamt_bad;

    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) valid_q <= 1'b0;
        else if (!block) valid_q <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            instr_q <= instr;
            pc_q    <= pc;
            rs1_q   <= rs1_data;
            rs2_q   <= rs2_data;
        end
    end

    assign opcode    = opcode_e'(instr_q[6:0]);
    assign funct3    = instr_q[14:12];
    assign funct7    = instr_q[31:25];
    assign imm_i     = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_b     = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                        instr_q[11:8], 1'b0};
    assign imm_u     = {instr_q[31:12], 12'b0};
    assign imm_j     = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                        instr_q[30:21], 1'b0};
    assign shamt_bad = (XLEN == 32) && instr_q[25]; // rv32 has only five shamt bits

    always_comb begin
        dec          = '0;
        dec.valid    = valid_q;
        dec.pc       = XLEN_MAX'(pc_q);
        dec.src1     = XLEN_MAX'(rs1_q);
        dec.src2     = XLEN_MAX'(rs2_q);
        dec.rd       = instr_q[11:7];
        dec.imm      = imm_i;
        dec.alu_op   = ALU_ADD;
        dec.src_a    = SRC_A_RS1;
        dec.src_b    = SRC_B_RS2;
        dec.branch   = BR_NONE;
        case (opcode)
            OPC_OP: begin
                dec.reg_wr  = 1'b1;
                dec.alu_op  = funct_op(funct3, funct7[5]);
                dec.illegal = funct7 != 7'b0 && !(funct7 == 7'b0100000 &&
                              (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                dec.reg_wr = 1'b1;
                dec.src_b  = SRC_B_IMM;
                dec.alu_op = funct_op(funct3, funct3 == 3'b101 && instr_q[30]);
                if (funct3 == 3'b001) dec.illegal = instr_q[31:26] != 6'b0 || shamt_bad;
                if (funct3 == 3'b101) dec.illegal = shamt_bad ||
                    (instr_q[31:26] != 6'b0 && instr_q[31:26] != 6'b010000);
            end
            OPC_LUI: begin
                dec.reg_wr = 1'b1;
                dec.src_b  = SRC_B_IMM;
                dec.alu_op = ALU_PASS_B;
                dec.imm    = imm_u;
            end
            OPC_AUIPC: begin
                dec.reg_wr = 1'b1;
                dec.src_a  = SRC_A_PC;
                dec.src_b  = SRC_B_IMM;
                dec.imm    = imm_u;
            end
            OPC_JAL, OPC_JALR: begin
                dec.reg_wr  = 1'b1;
                dec.src_a   = SRC_A_PC; // alu forms the link value pc + 4
                dec.src_b   = SRC_B_FOUR;
                dec.imm     = (opcode == OPC_JAL) ? imm_j : imm_i;
                dec.branch  = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
                dec.illegal = opcode == OPC_JALR && funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.branch = BR_BEQ;
                    3'b001:  dec.branch = BR_BNE;
                    3'b100:  dec.branch = BR_BLT;
                    3'b101:  dec.branch = BR_BGE;
                    3'b110:  dec.branch = BR_BLTU;
                    3'b111:  dec.branch = BR_BGEU;
                    default: dec.illegal = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                dec.is_ecall = instr_q == 32'h0000_0073;
                dec.illegal  = instr_q != 32'h0000_0073;
            end
            default: dec.illegal = 1'b1;
        endcase
        if (dec.illegal) begin
            dec.reg_wr = 1'b0; // a bad encoding must neither write nor redirect
            dec.branch = BR_NONE;
        end
    end

    a_no_wr_on_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        dec.valid |-> !(dec.reg_wr && dec.illegal));

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module execute_stage #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              block,
    input  logic              raise_intr,
    input  rv_exec_pkg::dec_t dec,
    output rv_exec_pkg::ex_t  ex
);
    import rv_exec_pkg::*;

    dec_t            dec_q;
    logic [XLEN-1:0] pc, src1, src2, imm;
    logic [XLEN-1:0] op_a, op_b;
    logic [XLEN-1:0] alu_result, nxtpc;
    alu_op_e         alu_op;
    logic            zero, taken;

    always_ff @(posedge clk) begin
        if (!block) dec_q <= dec;
        if (!rst_n) dec_q.valid <= 1'b0; // only the valid bit sees reset
    end

    assign pc   = dec_q.pc[XLEN-1:0];
    assign src1 = dec_q.src1[XLEN-1:0];
    assign src2 = dec_q.src2[XLEN-1:0];
    assign imm  = XLEN'($signed(dec_q.imm));
    assign op_a = (dec_q.src_a == SRC_A_PC) ? pc : src1;

    always_comb begin
        case (dec_q.src_b)
            SRC_B_RS2:  op_b = src2;
            SRC_B_FOUR: op_b = XLEN'(4);
            SRC_B_IMM:  op_b = imm;
            default:    op_b = '0;
        endcase
    end

    // conditional branches borrow the alu to compare rs1 with rs2
    always_comb begin
        case (dec_q.branch)
            BR_BEQ, BR_BNE:   alu_op = ALU_SUB;
            BR_BLT, BR_BGE:   alu_op = ALU_SLT;
            BR_BLTU, BR_BGEU: alu_op = ALU_SLTU;
            default:          alu_op = dec_q.alu_op;
        endcase
    end

    alu #(.XLEN(XLEN)) i_alu (
        .a(op_a), .b(op_b), .op(alu_op), .result(alu_result), .zero(zero)
    );

    branch_unit #(.XLEN(XLEN)) i_branch (
        .pc(pc), .src1(src1), .imm(imm), .branch(dec_q.branch),
        .zero(zero), .lt(alu_result[0]), .nxtpc(nxtpc), .taken(taken)
    );

    always_comb begin
        ex.valid    = dec_q.valid && (dec_q.is_ecall || !raise_intr); // ecall survives
        ex.rd       = dec_q.rd;
        ex.result   = XLEN_MAX'(alu_result);
        ex.reg_wr   = dec_q.reg_wr;
        ex.is_jmp   = taken && dec_q.valid;
        ex.nxtpc    = XLEN_MAX'(nxtpc);
        ex.is_ecall = dec_q.is_ecall;
        ex.illegal  = dec_q.illegal;
    end

    a_xlen_fits: assert property (@(posedge clk)
        XLEN <= XLEN_MAX && (XLEN == 32 || XLEN == 64));

    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        block |=> $stable(dec_q.valid));

endmodule

`default_nettype wire

/* hw/result_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module result_stage #(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             block,
    input  rv_exec_pkg::ex_t ex,
    output logic             wb_valid,
    output logic [4:0]       wb_rd,
    output logic [XLEN-1:0]  wb_data,
    output logic             wb_en,
    output logic             redirect,
    output logic [XLEN-1:0]  redirect_pc,
    output logic             ecall,
    output logic             error
);
    import rv_exec_pkg::*;

    ex_t ex_q;

    always_ff @(posedge clk) begin
        if (!block) ex_q <= ex;
        if (!rst_n) ex_q.valid <= 1'b0;
    end

    assign wb_valid    = ex_q.valid;
    assign wb_rd       = ex_q.rd;
    assign wb_en       = ex_q.valid && ex_q.reg_wr && ex_q.rd != 5'd0; // x0 is never written
    assign wb_data     = wb_en ? ex_q.result[XLEN-1:0] : '0;
    assign redirect    = ex_q.valid && ex_q.is_jmp;
    assign redirect_pc = ex_q.nxtpc[XLEN-1:0];
    assign ecall       = ex_q.valid && ex_q.is_ecall;
    assign error       = ex_q.valid && ex_q.illegal;

    a_no_redirect_on_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect && error));

endmodule

`default_nettype wire

/* hw/rv_exec_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_exec_core #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            block,
    input  logic            raise_intr,
    input  logic [31:0]     instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            wb_valid,
    output logic            wb_en,
    output logic            redirect,
    output logic            ecall,
    output logic            error,
    output logic [4:0]      wb_rd,
    output logic [XLEN-1:0] wb_data,
    output logic [XLEN-1:0] redirect_pc
);
    import rv_exec_pkg::*;

    dec_t dec_bus;
    ex_t  ex_bus;

    decode_stage #(.XLEN(XLEN)) i_decode (
        .clk(clk), .rst_n(rst_n), .block(block), .in_valid(in_valid), .instr(instr),
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec_bus)
    );

    execute_stage #(.XLEN(XLEN)) i_execute (
        .clk(clk), .rst_n(rst_n), .block(block), .raise_intr(raise_intr),
        .dec(dec_bus), .ex(ex_bus)
    );

    result_stage #(.XLEN(XLEN)) i_result (
        .clk(clk), .rst_n(rst_n), .block(block), .ex(ex_bus),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_en(wb_en),
        .redirect(redirect), .redirect_pc(redirect_pc), .ecall(ecall), .error(error)
    );

endmodule

`default_nettype wire

/* bench/rv_exec_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_exec_checker #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            block,
    input  logic            wb_valid,
    input  logic            wb_en,
    input  logic [4:0]      wb_rd,
    input  logic [XLEN-1:0] wb_data,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            ecall,
    input  logic            error,
    input  logic            exp_push,
    input  logic            exp_valid,
    input  logic            exp_wb_en,
    input  logic [4:0]      exp_rd,
    input  logic [XLEN-1:0] exp_data,
    input  logic            exp_redirect,
    input  logic [XLEN-1:0] exp_rpc,
    input  logic            exp_ecall,
    input  logic            exp_error,
    input  logic            send_done,
    output logic            done,
    output int              pass_count,
    output int              fail_count
);

    typedef struct packed {
        logic            valid;
        logic            wb_en;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic            redirect;
        logic [XLEN-1:0] rpc;
        logic            ecall;
        logic            error;
    } exp_rec_t;

    exp_rec_t exp_q[$];
    int       test_no;

    always @(posedge clk) begin
        if (exp_push) begin
            exp_q.push_back({exp_valid, exp_wb_en, exp_rd, exp_data, exp_redirect,
                             exp_rpc, exp_ecall, exp_error});
        end
    end

    // an output counts once, on the first edge where block is low
    task automatic check_writeback(input exp_rec_t rec);
        int cnt;
        int errs;
        cnt  = 0;
        errs = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!(wb_valid && !block) && cnt < 50);
        if (!(wb_valid && !block)) begin
            $display("test %0d: no writeback arrived within 50 cycles", test_no);
            fail_count++;
            return;
        end
        if (wb_en !== rec.wb_en) begin
            $display("FAIL test %0d wb_en got %h expected %h", test_no, wb_en, rec.wb_en);
            errs++;
        end
        if (rec.wb_en && wb_rd !== rec.rd) begin
            $display("FAIL test %0d wb_rd got %h expected %h", test_no, wb_rd, rec.rd);
            errs++;
        end
        if (wb_data !== rec.data) begin
            $display("FAIL test %0d wb_data got %h expected %h", test_no, wb_data, rec.data);
            errs++;
        end
        if (redirect !== rec.redirect) begin
            $display("FAIL test %0d redirect got %h expected %h", test_no, redirect,
                     rec.redirect);
            errs++;
        end
        if (rec.redirect && redirect_pc !== rec.rpc) begin
            $display("FAIL test %0d redirect_pc got %h expected %h", test_no, redirect_pc,
                     rec.rpc);
            errs++;
        end
        if (ecall !== rec.ecall) begin
            $display("FAIL test %0d ecall got %h expected %h", test_no, ecall, rec.ecall);
            errs++;
        end
        if (error !== rec.error) begin
            $display("FAIL test %0d error got %h expected %h", test_no, error, rec.error);
            errs++;
        end
        if (errs == 0) begin
            $display("test %0d ok", test_no);
            pass_count++;
        end else begin
            $display("test %0d failed with %0d mismatches", test_no, errs);
            fail_count++;
        end
    endtask

    task automatic check_killed();
        int seen;
        seen = 0;
        repeat (6) begin
            @(negedge clk);
            if (wb_valid && !block) seen++;
        end
        if (seen != 0) begin
            $display("test %0d: an instruction killed by the interrupt still came out",
                     test_no);
            fail_count++;
        end else begin
            $display("test %0d ok, killed as expected", test_no);
            pass_count++;
        end
    endtask

    initial begin
        exp_rec_t rec;
        int       wait_cnt;
        logic     finished;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_no    = 0;
        finished   = 1'b0;
        while (!finished) begin
            wait_cnt = 0;
            while (exp_q.size() == 0 && !send_done && wait_cnt < 200) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (exp_q.size() == 0) begin
                if (!send_done) begin
                    $display("no expected record arrived within 200 cycles");
                    fail_count++;
                end
                finished = 1'b1;
            end else begin
                rec = exp_q.pop_front();
                test_no++;
                if (rec.valid) check_writeback(rec);
                else check_killed();
            end
        end
        $display("tests %0d, passed %0d, failed %0d", test_no, pass_count, fail_count);
        done = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/rv_exec_core_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_exec_core_tb;

    localparam int XLEN = 64;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            block;
    logic            raise_intr;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            wb_valid;
    logic            wb_en;
    logic            redirect;
    logic            ecall;
    logic            error;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] redirect_pc;

    logic            exp_push;
    logic            exp_valid;
    logic            exp_wb_en;
    logic [4:0]      exp_rd;
    logic [XLEN-1:0] exp_data;
    logic            exp_redirect;
    logic [XLEN-1:0] exp_rpc;
    logic            exp_ecall;
    logic            exp_error;
    logic            send_done;
    logic            chk_done;
    int              pass_count;
    int              fail_count;

    rv_exec_core #(.XLEN(XLEN)) i_dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .block(block),
        .raise_intr(raise_intr), .instr(instr), .pc(pc), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wb_valid(wb_valid), .wb_en(wb_en), .redirect(redirect),
        .ecall(ecall), .error(error), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect_pc(redirect_pc)
    );

    rv_exec_checker #(.XLEN(XLEN)) i_chk (
        .clk(clk), .block(block), .wb_valid(wb_valid), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data), .redirect(redirect), .redirect_pc(redirect_pc),
        .ecall(ecall), .error(error), .exp_push(exp_push), .exp_valid(exp_valid),
        .exp_wb_en(exp_wb_en), .exp_rd(exp_rd), .exp_data(exp_data),
        .exp_redirect(exp_redirect), .exp_rpc(exp_rpc), .exp_ecall(exp_ecall),
        .exp_error(exp_error), .send_done(send_done), .done(chk_done),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one cycle with nothing offered, optionally frozen
    task automatic idle_cycle(input logic freeze, input logic intr);
        @(posedge clk);
        in_valid   <= 1'b0;
        exp_push   <= 1'b0;
        block      <= freeze;
        raise_intr <= intr;
    endtask

    initial begin
        int          fd;
        int          n;
        int          wait_cnt;
        string       line;
        logic [31:0] f_instr, f_blk, f_intr, f_valid, f_wb_en, f_rd;
        logic [31:0] f_redirect, f_ecall, f_error;
        logic [63:0] f_pc, f_rs1, f_rs2, f_data, f_rpc;

        rst_n        = 1'b0;
        in_valid     = 1'b0;
        block        = 1'b0;
        raise_intr   = 1'b0;
        instr        = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        exp_push     = 1'b0;
        exp_valid    = 1'b0;
        exp_wb_en    = 1'b0;
        exp_rd       = '0;
        exp_data     = '0;
        exp_redirect = 1'b0;
        exp_rpc      = '0;
        exp_ecall    = 1'b0;
        exp_error    = 1'b0;
        send_done    = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        fd = $fopen("bench/rv_exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 8 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f_instr, f_pc, f_rs1, f_rs2, f_blk, f_intr, f_valid,
                                f_wb_en, f_rd, f_data, f_redirect, f_rpc, f_ecall, f_error);
                    if (n == 14) begin
                        @(posedge clk);
                        in_valid     <= 1'b1;
                        block        <= 1'b0;
                        instr        <= f_instr;
                        pc           <= f_pc;
                        rs1_data     <= f_rs1;
                        rs2_data     <= f_rs2;
                        exp_push     <= 1'b1;
                        exp_valid    <= f_valid[0];
                        exp_wb_en    <= f_wb_en[0];
                        exp_rd       <= f_rd[4:0];
                        exp_data     <= f_data;
                        exp_redirect <= f_redirect[0];
                        exp_rpc      <= f_rpc;
                        exp_ecall    <= f_ecall[0];
                        exp_error    <= f_error[0];
                        if (f_intr[0]) begin
                            idle_cycle(1'b0, 1'b0);
                            idle_cycle(1'b0, 1'b1); // the record sits in execute now
                            repeat (8) idle_cycle(1'b0, 1'b0); // checker watches for silence
                        end
                        repeat (f_blk) idle_cycle(1'b1, 1'b0);
                        if (f_instr[6:0] == 7'h6f || f_instr[6:0] == 7'h67 ||
                            f_instr[6:0] == 7'h63) begin
                            repeat (2) idle_cycle(1'b0, 1'b0);
                        end
                    end
                end
            end
            $fclose(fd);
        end
        idle_cycle(1'b0, 1'b0);
        send_done <= 1'b1;

        wait_cnt = 0;
        while (!chk_done && wait_cnt < 2000) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!chk_done) begin
            $display("checker did not finish within 2000 cycles");
        end
        if (!chk_done || fail_count != 0 || pass_count == 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rv_exec_stimulus.txt */
# instr pc rs1 rs2 block_cycles intr | exp: valid wb_en rd data redirect redirect_pc ecall error
# all fields hex, x1/x2 are the sources and x3 the destination unless noted
002081b3 1000 7fffffffffffffff 1 0 0 1 1 3 8000000000000000 0 0 0 0
402081b3 1004 0 1 0 0 1 1 3 ffffffffffffffff 0 0 0 0
0020a1b3 1008 ffffffffffffffff 1 0 0 1 1 3 1 0 0 0 0
0020b1b3 100c ffffffffffffffff 1 0 0 1 1 3 0 0 0 0 0
4020d1b3 1010 8000000000000000 4 0 0 1 1 3 f800000000000000 0 0 0 0
0020d1b3 1014 8000000000000000 4 0 0 1 1 3 0800000000000000 0 0 0 0
002091b3 1018 1 43 0 0 1 1 3 8 0 0 0 0
0020c1b3 101c 00000000ffff0000 0000ffff0000ffff 0 0 1 1 3 0000ffffffffffff 0 0 0 0
0020e1b3 1020 f0 0f 0 0 1 1 3 ff 0 0 0 0
0020f1b3 1024 ff00 0ff0 0 0 1 1 3 f00 0 0 0 0
fff08193 1028 5 0 0 0 1 1 3 4 0 0 0 0
fff0b193 102c 5 0 0 0 1 1 3 1 0 0 0 0
43f0d193 1030 8000000000000000 0 0 0 1 1 3 ffffffffffffffff 0 0 0 0
800001b7 1034 0 0 0 0 1 1 3 ffffffff80000000 0 0 0 0
00001197 2000 0 0 0 0 1 1 3 3000 0 0 0 0
010000ef 3000 0 0 0 0 1 1 1 3004 1 3010 0 0
003082e7 3100 4000 0 0 0 1 1 5 3104 1 4002 0 0
00208463 5000 5 5 0 0 1 0 0 0 1 5008 0 0
00209463 5004 5 5 0 0 1 0 0 0 0 0 0 0
0020c463 5100 ffffffffffffffff 1 0 0 1 0 0 0 1 5108 0 0
0020f463 5200 ffffffffffffffff 1 0 0 1 0 0 0 1 5208 0 0
0020e463 5300 ffffffffffffffff 1 0 0 1 0 0 0 0 0 0 0
00208033 6000 1 2 0 0 1 0 0 0 0 0 0 0
ffffffff 6004 0 0 0 0 1 0 0 0 0 0 0 1
002081b3 6008 10 20 3 0 1 1 3 30 0 0 0 0
402081b3 600c 50 8 2 0 1 1 3 48 0 0 0 0
002081b3 6010 1 1 0 0 1 1 3 2 0 0 0 0
002081b3 7000 1 2 0 1 0 0 0 0 0 0 0 0
00000073 7004 0 0 0 1 1 0 0 0 0 0 1 0

/* rv_exec_core.f */
hw/rv_exec_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv_exec_core.sv
bench/rv_exec_checker.sv
bench/rv_exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute-core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_exec_core_tb -f rv_exec_core.f \
    --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
exit 1
